//--- rtl/rv_exec_pkg.sv
package rv_exec_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [3:0]  alu_op_t;
	typedef logic [2:0]  ld_kind_t;
	typedef logic [1:0]  st_kind_t;
	typedef logic [1:0]  jump_kind_t;

	// base opcodes, inst[6:0]
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	localparam alu_op_t ALU_ADD  = 4'd0;
	localparam alu_op_t ALU_SUB  = 4'd1;
	localparam alu_op_t ALU_SLL  = 4'd2;
	localparam alu_op_t ALU_SLT  = 4'd3;
	localparam alu_op_t ALU_SLTU = 4'd4;
	localparam alu_op_t ALU_XOR  = 4'd5;
	localparam alu_op_t ALU_SRL  = 4'd6;
	localparam alu_op_t ALU_SRA  = 4'd7;
	localparam alu_op_t ALU_OR   = 4'd8;
	localparam alu_op_t ALU_AND  = 4'd9;
	localparam alu_op_t ALU_LUI  = 4'd10;
	localparam alu_op_t ALU_EQ   = 4'd11;
	localparam alu_op_t ALU_NE   = 4'd12;
	localparam alu_op_t ALU_LT   = 4'd13;
	localparam alu_op_t ALU_GE   = 4'd14;
	// unsigned less-than is the same function as sltu
	localparam alu_op_t ALU_LTU  = ALU_SLTU;
	localparam alu_op_t ALU_GEU  = 4'd15;

	localparam ld_kind_t LD_NONE = 3'd0;
	localparam ld_kind_t LD_B    = 3'd1;
	localparam ld_kind_t LD_BU   = 3'd2;
	localparam ld_kind_t LD_H    = 3'd3;
	localparam ld_kind_t LD_HU   = 3'd4;
	localparam ld_kind_t LD_W    = 3'd5;

	localparam st_kind_t ST_NONE = 2'd0;
	localparam st_kind_t ST_B    = 2'd1;
	localparam st_kind_t ST_H    = 2'd2;
	localparam st_kind_t ST_W    = 2'd3;

	localparam jump_kind_t JMP_NONE   = 2'd0;
	localparam jump_kind_t JMP_JAL    = 2'd1;
	localparam jump_kind_t JMP_JALR   = 2'd2;
	localparam jump_kind_t JMP_BRANCH = 2'd3;

	localparam int DMEM_WORDS = 256;
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);

	localparam logic [1:0] RESP_OKAY = 2'b00;

	typedef enum logic [1:0] {IDLE_R, WAIT_ARREADY, WAIT_RVALID, DONE_R} rd_state_e;
	typedef enum logic [2:0] {IDLE_W, WAIT_AWREADY, WAIT_WREADY, WAIT_BVALID, DONE_W} wr_state_e;

endpackage

//--- rtl/regfile.sv
`timescale 1ns/100ps

module regfile (
	input  logic                   clk,
	input  logic                   rst,
	input  rv_exec_pkg::reg_addr_t rs1,
	input  rv_exec_pkg::reg_addr_t rs2,
	output rv_exec_pkg::word_t     rs1_data,
	output rv_exec_pkg::word_t     rs2_data,
	input  logic                   wen,
	input  rv_exec_pkg::reg_addr_t waddr,
	input  rv_exec_pkg::word_t     wdata
);

	// x0 has no storage
	rv_exec_pkg::word_t regs [1:31];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

//--- rtl/idu.sv
`timescale 1ns/100ps

module idu (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    in_valid,
	input  rv_exec_pkg::word_t      in_pc,
	input  rv_exec_pkg::word_t      in_inst,
	output logic                    in_ready,
	output rv_exec_pkg::reg_addr_t  rs1,
	output rv_exec_pkg::reg_addr_t  rs2,
	input  rv_exec_pkg::word_t      rs1_data,
	input  rv_exec_pkg::word_t      rs2_data,
	input  logic                    exu_pend_valid,
	input  rv_exec_pkg::reg_addr_t  exu_pend_rd,
	input  logic                    exu_allowin,
	output logic                    id_valid,
	output rv_exec_pkg::word_t      id_pc,
	output rv_exec_pkg::word_t      id_src1,
	output rv_exec_pkg::word_t      id_src2,
	output rv_exec_pkg::word_t      id_imm,
	output rv_exec_pkg::word_t      id_store_data,
	output rv_exec_pkg::reg_addr_t  id_rd,
	output logic                    id_rd_wen,
	output rv_exec_pkg::alu_op_t    id_alu_op,
	output logic                    id_alu_use_imm,
	output logic                    id_alu_use_pc,
	output rv_exec_pkg::ld_kind_t   id_ld_kind,
	output rv_exec_pkg::st_kind_t   id_st_kind,
	output rv_exec_pkg::jump_kind_t id_jump_kind
);

	logic                 idu_valid;
	rv_exec_pkg::word_t   pc_q;
	rv_exec_pkg::word_t   inst_q;
	logic [6:0]           opcode;
	logic [2:0]           funct3;
	logic                 use_rs1;
	logic                 use_rs2;
	logic                 hazard;
	logic                 ready_go;
	rv_exec_pkg::alu_op_t arith_op;

	always_ff @(posedge clk) begin
		if (rst) begin
			idu_valid <= 1'b0;
		end else if (in_ready) begin
			idu_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid && in_ready) begin
			pc_q   <= in_pc;
			inst_q <= in_inst;
		end
	end

	assign opcode = inst_q[6:0];
	assign funct3 = inst_q[14:12];
	assign rs1    = inst_q[19:15];
	assign rs2    = inst_q[24:20];

	// lui, auipc and jal carry no rs1
	assign use_rs1 = !(opcode == rv_exec_pkg::OPC_LUI || opcode == rv_exec_pkg::OPC_AUIPC ||
		opcode == rv_exec_pkg::OPC_JAL);
	assign use_rs2 = opcode == rv_exec_pkg::OPC_BRANCH || opcode == rv_exec_pkg::OPC_STORE ||
		opcode == rv_exec_pkg::OPC_OP;

	// wait until the instruction in exu has written its rd
	assign hazard = exu_pend_valid && exu_pend_rd != '0 &&
		((use_rs1 && rs1 == exu_pend_rd) || (use_rs2 && rs2 == exu_pend_rd));
	assign ready_go = !hazard;
	assign id_valid = idu_valid && ready_go;
	assign in_ready = !idu_valid || (ready_go && exu_allowin);

	assign id_pc         = pc_q;
	assign id_src1       = rs1_data;
	assign id_src2       = rs2_data;
	assign id_store_data = rs2_data;
	assign id_rd         = inst_q[11:7];

	// inst[30] selects sub only in register form, sra in both
	always_comb begin
		case (funct3)
			3'b000:  arith_op = (opcode == rv_exec_pkg::OPC_OP && inst_q[30]) ?
				rv_exec_pkg::ALU_SUB : rv_exec_pkg::ALU_ADD;
			3'b001:  arith_op = rv_exec_pkg::ALU_SLL;
			3'b010:  arith_op = rv_exec_pkg::ALU_SLT;
			3'b011:  arith_op = rv_exec_pkg::ALU_SLTU;
			3'b100:  arith_op = rv_exec_pkg::ALU_XOR;
			3'b101:  arith_op = inst_q[30] ? rv_exec_pkg::ALU_SRA : rv_exec_pkg::ALU_SRL;
			3'b110:  arith_op = rv_exec_pkg::ALU_OR;
			default: arith_op = rv_exec_pkg::ALU_AND;
		endcase
	end

	always_comb begin
		id_imm         = {{20{inst_q[31]}}, inst_q[31:20]};
		id_rd_wen      = 1'b1;
		id_alu_op      = rv_exec_pkg::ALU_ADD;
		id_alu_use_imm = 1'b1;
		id_alu_use_pc  = 1'b0;
		id_ld_kind     = rv_exec_pkg::LD_NONE;
		id_st_kind     = rv_exec_pkg::ST_NONE;
		id_jump_kind   = rv_exec_pkg::JMP_NONE;
		case (opcode)
			rv_exec_pkg::OPC_LUI: begin
				id_imm    = {inst_q[31:12], 12'b0};
				id_alu_op = rv_exec_pkg::ALU_LUI;
			end
			rv_exec_pkg::OPC_AUIPC: begin
				id_imm        = {inst_q[31:12], 12'b0};
				id_alu_use_pc = 1'b1;
			end
			rv_exec_pkg::OPC_JAL: begin
				id_imm = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20],
					inst_q[30:21], 1'b0};
				id_alu_use_pc = 1'b1;
				id_jump_kind  = rv_exec_pkg::JMP_JAL;
			end
			rv_exec_pkg::OPC_JALR: id_jump_kind = rv_exec_pkg::JMP_JALR;
			rv_exec_pkg::OPC_BRANCH: begin
				id_imm = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25],
					inst_q[11:8], 1'b0};
				id_rd_wen      = 1'b0;
				id_alu_use_imm = 1'b0;
				id_jump_kind   = rv_exec_pkg::JMP_BRANCH;
				case (funct3)
					3'b000:  id_alu_op = rv_exec_pkg::ALU_EQ;
					3'b001:  id_alu_op = rv_exec_pkg::ALU_NE;
					3'b100:  id_alu_op = rv_exec_pkg::ALU_LT;
					3'b101:  id_alu_op = rv_exec_pkg::ALU_GE;
					3'b110:  id_alu_op = rv_exec_pkg::ALU_LTU;
					default: id_alu_op = rv_exec_pkg::ALU_GEU;
				endcase
			end
			rv_exec_pkg::OPC_LOAD: begin
				case (funct3)
					3'b000:  id_ld_kind = rv_exec_pkg::LD_B;
					3'b001:  id_ld_kind = rv_exec_pkg::LD_H;
					3'b100:  id_ld_kind = rv_exec_pkg::LD_BU;
					3'b101:  id_ld_kind = rv_exec_pkg::LD_HU;
					default: id_ld_kind = rv_exec_pkg::LD_W;
				endcase
			end
			rv_exec_pkg::OPC_STORE: begin
				id_imm    = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
				id_rd_wen = 1'b0;
				case (funct3[1:0])
					2'b00:   id_st_kind = rv_exec_pkg::ST_B;
					2'b01:   id_st_kind = rv_exec_pkg::ST_H;
					default: id_st_kind = rv_exec_pkg::ST_W;
				endcase
			end
			rv_exec_pkg::OPC_OP: begin
				id_alu_use_imm = 1'b0;
				id_alu_op      = arith_op;
			end
			default: id_alu_op = arith_op;
		endcase
	end

endmodule

//--- rtl/alu.sv
`timescale 1ns/100ps

module alu (
	input  rv_exec_pkg::alu_op_t op,
	input  rv_exec_pkg::word_t   a,
	input  rv_exec_pkg::word_t   b,
	output rv_exec_pkg::word_t   result
);

	logic [4:0] shamt;
	logic       lt;
	logic       ltu;
	logic       eq;

	assign shamt = b[4:0];
	assign lt    = $signed(a) < $signed(b);
	assign ltu   = a < b;
	assign eq    = a == b;

	always_comb begin
		case (op)
			rv_exec_pkg::ALU_ADD:  result = a + b;
			rv_exec_pkg::ALU_SUB:  result = a - b;
			rv_exec_pkg::ALU_SLL:  result = a << shamt;
			rv_exec_pkg::ALU_SLT:  result = {31'b0, lt};
			// also serves bltu
			rv_exec_pkg::ALU_SLTU: result = {31'b0, ltu};
			rv_exec_pkg::ALU_XOR:  result = a ^ b;
			rv_exec_pkg::ALU_SRL:  result = a >> shamt;
			rv_exec_pkg::ALU_SRA:  result = $signed(a) >>> shamt;
			rv_exec_pkg::ALU_OR:   result = a | b;
			rv_exec_pkg::ALU_AND:  result = a & b;
			rv_exec_pkg::ALU_LUI:  result = b;
			rv_exec_pkg::ALU_EQ:   result = {31'b0, eq};
			rv_exec_pkg::ALU_NE:   result = {31'b0, !eq};
			rv_exec_pkg::ALU_LT:   result = {31'b0, lt};
			rv_exec_pkg::ALU_GE:   result = {31'b0, !lt};
			default:               result = {31'b0, !ltu};
		endcase
	end

endmodule

//--- rtl/exu.sv
`timescale 1ns/100ps

module exu (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    id_valid,
	input  rv_exec_pkg::word_t      id_pc,
	input  rv_exec_pkg::word_t      id_src1,
	input  rv_exec_pkg::word_t      id_src2,
	input  rv_exec_pkg::word_t      id_imm,
	input  rv_exec_pkg::word_t      id_store_data,
	input  rv_exec_pkg::reg_addr_t  id_rd,
	input  logic                    id_rd_wen,
	input  rv_exec_pkg::alu_op_t    id_alu_op,
	input  logic                    id_alu_use_imm,
	input  logic                    id_alu_use_pc,
	input  rv_exec_pkg::ld_kind_t   id_ld_kind,
	input  rv_exec_pkg::st_kind_t   id_st_kind,
	input  rv_exec_pkg::jump_kind_t id_jump_kind,
	output logic                    exu_allowin,
	output logic                    exu_pend_valid,
	output rv_exec_pkg::reg_addr_t  exu_pend_rd,
	output rv_exec_pkg::word_t      awaddr,
	output logic                    awvalid,
	input  logic                    awready,
	output rv_exec_pkg::word_t      wdata,
	output logic [3:0]              wstrb,
	output logic                    wvalid,
	input  logic                    wready,
	input  logic [1:0]              bresp,
	input  logic                    bvalid,
	output logic                    bready,
	output rv_exec_pkg::word_t      araddr,
	output logic                    arvalid,
	input  logic                    arready,
	input  rv_exec_pkg::word_t      rdata,
	input  logic [1:0]              rresp,
	input  logic                    rvalid,
	output logic                    rready,
	output logic                    commit_valid,
	output rv_exec_pkg::word_t      commit_pc,
	output rv_exec_pkg::word_t      commit_next_pc,
	output logic                    rf_wen,
	output rv_exec_pkg::reg_addr_t  rf_waddr,
	output rv_exec_pkg::word_t      rf_wdata
);

	logic                    exu_valid;
	logic                    exu_ready_go;
	rv_exec_pkg::word_t      ex_pc, ex_src1, ex_src2, ex_imm, ex_store_data;
	rv_exec_pkg::reg_addr_t  ex_rd;
	logic                    ex_rd_wen, ex_use_imm, ex_use_pc;
	rv_exec_pkg::alu_op_t    ex_alu_op;
	rv_exec_pkg::ld_kind_t   ex_ld_kind;
	rv_exec_pkg::st_kind_t   ex_st_kind;
	rv_exec_pkg::jump_kind_t ex_jump_kind;
	rv_exec_pkg::word_t      alu_result, pc_plus4, next_pc, load_shifted, load_data;
	logic [4:0]              byte_shift;
	logic                    read_start, write_start, read_done, write_done;
	rv_exec_pkg::rd_state_e  rd_state, rd_next;
	rv_exec_pkg::wr_state_e  wr_state, wr_next;

	always_ff @(posedge clk) begin
		if (rst) begin
			exu_valid <= 1'b0;
		end else if (exu_allowin) begin
			exu_valid <= id_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (exu_allowin && id_valid) begin
			ex_pc         <= id_pc;
			ex_src1       <= id_src1;
			ex_src2       <= id_src2;
			ex_imm        <= id_imm;
			ex_store_data <= id_store_data;
			ex_rd         <= id_rd;
			ex_rd_wen     <= id_rd_wen;
			ex_alu_op     <= id_alu_op;
			ex_use_imm    <= id_alu_use_imm;
			ex_use_pc     <= id_alu_use_pc;
			ex_ld_kind    <= id_ld_kind;
			ex_st_kind    <= id_st_kind;
			ex_jump_kind  <= id_jump_kind;
		end
	end

	alu i_alu (
		.op     (ex_alu_op),
		.a      (ex_use_pc ? ex_pc : ex_src1),
		.b      (ex_use_imm ? ex_imm : ex_src2),
		.result (alu_result)
	);

	// alu_result is the jump target for jal/jalr and the compare bit for branches
	assign pc_plus4 = ex_pc + 32'd4;
	always_comb begin
		case (ex_jump_kind)
			rv_exec_pkg::JMP_JAL:    next_pc = alu_result;
			rv_exec_pkg::JMP_JALR:   next_pc = {alu_result[31:1], 1'b0};
			rv_exec_pkg::JMP_BRANCH: next_pc = alu_result[0] ? ex_pc + ex_imm : pc_plus4;
			default:                 next_pc = pc_plus4;
		endcase
	end

	assign read_start  = exu_valid && ex_ld_kind != rv_exec_pkg::LD_NONE;
	assign write_start = exu_valid && ex_st_kind != rv_exec_pkg::ST_NONE;
	assign read_done   = rvalid && rready && rresp == rv_exec_pkg::RESP_OKAY;
	assign write_done  = bvalid && bready && bresp == rv_exec_pkg::RESP_OKAY;

	assign exu_ready_go = read_start ? read_done : write_start ? write_done : 1'b1;
	assign exu_allowin  = !exu_valid || exu_ready_go;

	always_ff @(posedge clk) begin
		if (rst) begin
			rd_state <= rv_exec_pkg::IDLE_R;
			wr_state <= rv_exec_pkg::IDLE_W;
		end else begin
			rd_state <= rd_next;
			wr_state <= wr_next;
		end
	end

	// an error response reissues the whole transaction
	always_comb begin
		rd_next = rd_state;
		case (rd_state)
			rv_exec_pkg::WAIT_ARREADY:
				if (arready) rd_next = rv_exec_pkg::WAIT_RVALID;
			rv_exec_pkg::WAIT_RVALID:
				if (rvalid) rd_next = read_done ? rv_exec_pkg::DONE_R : rv_exec_pkg::WAIT_ARREADY;
			default:
				if (!read_start) rd_next = rv_exec_pkg::IDLE_R;
				else rd_next = arready ? rv_exec_pkg::WAIT_RVALID : rv_exec_pkg::WAIT_ARREADY;
		endcase
	end

	always_comb begin
		wr_next = wr_state;
		case (wr_state)
			rv_exec_pkg::WAIT_AWREADY:
				if (awready) wr_next = rv_exec_pkg::WAIT_WREADY;
			rv_exec_pkg::WAIT_WREADY:
				if (wready) wr_next = rv_exec_pkg::WAIT_BVALID;
			rv_exec_pkg::WAIT_BVALID:
				if (bvalid) wr_next = write_done ? rv_exec_pkg::DONE_W : rv_exec_pkg::WAIT_AWREADY;
			default:
				if (!write_start) wr_next = rv_exec_pkg::IDLE_W;
				else wr_next = awready ? rv_exec_pkg::WAIT_WREADY : rv_exec_pkg::WAIT_AWREADY;
		endcase
	end

	assign arvalid = read_start && rd_state != rv_exec_pkg::WAIT_RVALID;
	assign rready  = rd_state == rv_exec_pkg::WAIT_RVALID;
	assign awvalid = write_start && (wr_state == rv_exec_pkg::IDLE_W ||
		wr_state == rv_exec_pkg::DONE_W || wr_state == rv_exec_pkg::WAIT_AWREADY);
	assign wvalid  = wr_state == rv_exec_pkg::WAIT_WREADY;
	assign bready  = wr_state == rv_exec_pkg::WAIT_BVALID;

	// lane placement from the low address bits
	assign byte_shift = {alu_result[1:0], 3'b000};
	assign araddr     = alu_result;
	assign awaddr     = alu_result;
	assign wdata      = ex_store_data << byte_shift;
	always_comb begin
		case (ex_st_kind)
			rv_exec_pkg::ST_B: wstrb = 4'b0001 << alu_result[1:0];
			rv_exec_pkg::ST_H: wstrb = 4'b0011 << alu_result[1:0];
			default:           wstrb = 4'b1111;
		endcase
	end

	assign load_shifted = rdata >> byte_shift;
	always_comb begin
		case (ex_ld_kind)
			rv_exec_pkg::LD_B:  load_data = {{24{load_shifted[7]}}, load_shifted[7:0]};
			rv_exec_pkg::LD_BU: load_data = {24'b0, load_shifted[7:0]};
			rv_exec_pkg::LD_H:  load_data = {{16{load_shifted[15]}}, load_shifted[15:0]};
			rv_exec_pkg::LD_HU: load_data = {16'b0, load_shifted[15:0]};
			default:            load_data = load_shifted;
		endcase
	end

	assign exu_pend_valid = exu_valid && ex_rd_wen;
	assign exu_pend_rd    = ex_rd;

	assign commit_valid   = exu_valid && exu_ready_go;
	assign commit_pc      = ex_pc;
	assign commit_next_pc = next_pc;
	assign rf_wen         = commit_valid && ex_rd_wen && ex_rd != '0;
	assign rf_waddr       = ex_rd;
	assign rf_wdata = (ex_jump_kind == rv_exec_pkg::JMP_JAL || ex_jump_kind == rv_exec_pkg::JMP_JALR) ?
		pc_plus4 : read_start ? load_data : alu_result;

endmodule

//--- rtl/dsram.sv
`timescale 1ns/100ps

module dsram (
	input  logic               clk,
	input  logic               rst,
	input  rv_exec_pkg::word_t awaddr,
	input  logic               awvalid,
	output logic               awready,
	input  rv_exec_pkg::word_t wdata,
	input  logic [3:0]         wstrb,
	input  logic               wvalid,
	output logic               wready,
	output logic [1:0]         bresp,
	output logic               bvalid,
	input  logic               bready,
	input  rv_exec_pkg::word_t araddr,
	input  logic               arvalid,
	output logic               arready,
	output rv_exec_pkg::word_t rdata,
	output logic [1:0]         rresp,
	output logic               rvalid,
	input  logic               rready
);

	rv_exec_pkg::word_t           mem [rv_exec_pkg::DMEM_WORDS];
	logic [15:0]                  lfsr;
	logic                         r_pend;
	logic                         aw_pend;
	logic                         w_got;
	logic [rv_exec_pkg::DMEM_AW-1:0] ridx;
	logic [rv_exec_pkg::DMEM_AW-1:0] widx;

	// each channel stalls about a quarter of the cycles
	assign arready = !r_pend && (lfsr[0] || lfsr[5]);
	assign awready = !aw_pend && (lfsr[2] || lfsr[9]);
	assign wready  = aw_pend && !w_got && (lfsr[4] || lfsr[11]);
	assign rresp   = rv_exec_pkg::RESP_OKAY;
	assign bresp   = rv_exec_pkg::RESP_OKAY;

	always_ff @(posedge clk) begin
		if (rst) begin
			lfsr    <= 16'hace1;
			r_pend  <= 1'b0;
			rvalid  <= 1'b0;
			aw_pend <= 1'b0;
			w_got   <= 1'b0;
			bvalid  <= 1'b0;
		end else begin
			lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			if (arvalid && arready) r_pend <= 1'b1;
			if (r_pend && !rvalid && (lfsr[7] || lfsr[14])) rvalid <= 1'b1;
			if (rvalid && rready) begin
				rvalid <= 1'b0;
				r_pend <= 1'b0;
			end
			if (awvalid && awready) aw_pend <= 1'b1;
			if (wvalid && wready) w_got <= 1'b1;
			if (w_got && !bvalid && (lfsr[1] || lfsr[12])) bvalid <= 1'b1;
			if (bvalid && bready) begin
				bvalid  <= 1'b0;
				aw_pend <= 1'b0;
				w_got   <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (arvalid && arready) ridx <= araddr[rv_exec_pkg::DMEM_AW+1:2];
		if (awvalid && awready) widx <= awaddr[rv_exec_pkg::DMEM_AW+1:2];
		if (r_pend && !rvalid) rdata <= mem[ridx];
	end

	// only strobed byte lanes change
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < rv_exec_pkg::DMEM_WORDS; i++) begin
				mem[i] <= '0;
			end
		end else if (wvalid && wready) begin
			for (int b = 0; b < 4; b++) begin
				if (wstrb[b]) mem[widx][8*b +: 8] <= wdata[8*b +: 8];
			end
		end
	end

endmodule

//--- rtl/rv_backend_top.sv
`timescale 1ns/100ps

module rv_backend_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   in_valid,
	output logic                   in_ready,
	input  rv_exec_pkg::word_t     in_pc,
	input  rv_exec_pkg::word_t     in_inst,
	output logic                   commit_valid,
	output rv_exec_pkg::word_t     commit_pc,
	output rv_exec_pkg::word_t     commit_next_pc,
	output logic                   rf_wen,
	output rv_exec_pkg::reg_addr_t rf_waddr,
	output rv_exec_pkg::word_t     rf_wdata
);

	rv_exec_pkg::reg_addr_t  rs1, rs2, id_rd, exu_pend_rd;
	rv_exec_pkg::word_t      rs1_data, rs2_data;
	logic                    id_valid, id_rd_wen, id_alu_use_imm, id_alu_use_pc;
	rv_exec_pkg::word_t      id_pc, id_src1, id_src2, id_imm, id_store_data;
	rv_exec_pkg::alu_op_t    id_alu_op;
	rv_exec_pkg::ld_kind_t   id_ld_kind;
	rv_exec_pkg::st_kind_t   id_st_kind;
	rv_exec_pkg::jump_kind_t id_jump_kind;
	logic                    exu_allowin, exu_pend_valid;
	rv_exec_pkg::word_t      awaddr, wdata, araddr, rdata;
	logic [3:0]              wstrb;
	logic [1:0]              bresp, rresp;
	logic                    awvalid, awready, wvalid, wready, bvalid, bready;
	logic                    arvalid, arready, rvalid, rready;

	idu i_idu (
		.clk, .rst, .in_valid, .in_pc, .in_inst, .in_ready,
		.rs1, .rs2, .rs1_data, .rs2_data,
		.exu_pend_valid, .exu_pend_rd, .exu_allowin,
		.id_valid, .id_pc, .id_src1, .id_src2, .id_imm, .id_store_data,
		.id_rd, .id_rd_wen, .id_alu_op, .id_alu_use_imm, .id_alu_use_pc,
		.id_ld_kind, .id_st_kind, .id_jump_kind
	);

	regfile i_regfile (
		.clk, .rst, .rs1, .rs2, .rs1_data, .rs2_data,
		.wen   (rf_wen),
		.waddr (rf_waddr),
		.wdata (rf_wdata)
	);

	exu i_exu (
		.clk, .rst,
		.id_valid, .id_pc, .id_src1, .id_src2, .id_imm, .id_store_data,
		.id_rd, .id_rd_wen, .id_alu_op, .id_alu_use_imm, .id_alu_use_pc,
		.id_ld_kind, .id_st_kind, .id_jump_kind,
		.exu_allowin, .exu_pend_valid, .exu_pend_rd,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.commit_valid, .commit_pc, .commit_next_pc, .rf_wen, .rf_waddr, .rf_wdata
	);

	dsram i_dsram (
		.clk, .rst,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready
	);

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic rst
);

	localparam int HALF_PERIOD = 10;
	localparam int RESET_CYCLES = 5;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	initial begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

//--- testbench/tb_rv_backend.sv
`timescale 1ns/100ps

module tb_rv_backend;

	localparam int N_INST = 2000;
	localparam int CYCLES_PER_INST = 40;
	localparam int DRAIN_CYCLES = 20;

	typedef struct packed {
		rv_exec_pkg::word_t     pc;
		rv_exec_pkg::word_t     npc;
		logic                   wen;
		rv_exec_pkg::reg_addr_t waddr;
		rv_exec_pkg::word_t     wdata;
		logic                   ctrl;
	} commit_t;

	logic                   clk;
	logic                   rst;
	logic                   in_valid;
	logic                   in_ready;
	rv_exec_pkg::word_t     in_pc;
	rv_exec_pkg::word_t     in_inst;
	logic                   commit_valid;
	rv_exec_pkg::word_t     commit_pc;
	rv_exec_pkg::word_t     commit_next_pc;
	logic                   rf_wen;
	rv_exec_pkg::reg_addr_t rf_waddr;
	rv_exec_pkg::word_t     rf_wdata;

	integer                 seed = 10;
	rv_exec_pkg::word_t     model_regs [32];
	logic [7:0]             model_mem [4*rv_exec_pkg::DMEM_WORDS];
	commit_t                exp_q [$];
	rv_exec_pkg::word_t     fetch_pc;
	logic                   presenting;
	logic                   cur_ctrl;
	logic                   wait_ctrl;
	logic                   mem_pending;
	rv_exec_pkg::reg_addr_t mem_base_reg;
	int                     generated;
	int                     committed;

	tb_clock i_clock (
		.clk (clk),
		.rst (rst)
	);

	rv_backend_top i_dut (
		.clk            (clk),
		.rst            (rst),
		.in_valid       (in_valid),
		.in_ready       (in_ready),
		.in_pc          (in_pc),
		.in_inst        (in_inst),
		.commit_valid   (commit_valid),
		.commit_pc      (commit_pc),
		.commit_next_pc (commit_next_pc),
		.rf_wen         (rf_wen),
		.rf_waddr       (rf_waddr),
		.rf_wdata       (rf_wdata)
	);

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input rv_exec_pkg::word_t expected,
		input rv_exec_pkg::word_t actual);
		assert (actual === expected) else
			abort_run($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
	endtask

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// RV32I integer op chosen by funct3 and the inst[30] bit in alt
	function automatic rv_exec_pkg::word_t arith(input logic [2:0] f3, input logic alt,
		input rv_exec_pkg::word_t a, input rv_exec_pkg::word_t b);
		rv_exec_pkg::word_t r;
		case (f3)
			3'd0: r = alt ? a - b : a + b;
			3'd1: r = a << b[4:0];
			3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: r = (a < b) ? 32'd1 : 32'd0;
			3'd4: r = a ^ b;
			3'd5: begin
				if (alt) r = $signed(a) >>> b[4:0];
				else r = a >> b[4:0];
			end
			3'd6: r = a | b;
			default: r = a & b;
		endcase
		return r;
	endfunction

	// pick, encode and execute one instruction in the model and present it
	task automatic gen_next;
		int                     cls;
		int                     size;
		int                     i;
		logic [2:0]             f3;
		logic                   alt;
		logic                   wen;
		logic                   ctrl;
		logic                   taken;
		logic                   is_load;
		logic [19:0]            imm20;
		rv_exec_pkg::reg_addr_t rd, rs1, rs2;
		rv_exec_pkg::word_t     a, b, imm, res, npc, addr, inst;
		commit_t                e;

		rd   = rand_below(8);
		rs1  = rand_below(8);
		rs2  = rand_below(8);
		alt  = 1'b0;
		wen  = 1'b1;
		ctrl = 1'b0;
		res  = '0;
		npc  = fetch_pc + 32'd4;
		cls  = mem_pending ? 10 : rand_below(10);
		if (mem_pending) rs1 = mem_base_reg;
		a = model_regs[rs1];
		b = model_regs[rs2];
		case (cls)
			0, 1, 2: begin
				f3  = rand_below(8);
				imm = rand_below(4096);
				imm = {{20{imm[11]}}, imm[11:0]};
				// shifts carry funct7 in the upper immediate bits
				if (f3 == 3'd1 || f3 == 3'd5) begin
					alt = (f3 == 3'd5) && rand_below(2) == 1;
					imm = {20'b0, 1'b0, alt, 5'b0, imm[4:0]};
				end
				res  = arith(f3, alt, a, imm);
				inst = {imm[11:0], rs1, f3, rd, rv_exec_pkg::OPC_OPIMM};
			end
			3, 4: begin
				f3   = rand_below(8);
				alt  = (f3 == 3'd0 || f3 == 3'd5) && rand_below(2) == 1;
				res  = arith(f3, alt, a, b);
				inst = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, rv_exec_pkg::OPC_OP};
			end
			5: begin
				imm20 = $random(seed);
				if (rand_below(2) == 0) begin
					res  = {imm20, 12'b0};
					inst = {imm20, rd, rv_exec_pkg::OPC_LUI};
				end else begin
					res  = fetch_pc + {imm20, 12'b0};
					inst = {imm20, rd, rv_exec_pkg::OPC_AUIPC};
				end
			end
			6: begin
				i    = rand_below(6);
				f3   = (i < 2) ? i : i + 2;
				imm  = (rand_below(33) - 16) * 4;
				wen  = 1'b0;
				ctrl = 1'b1;
				case (f3)
					3'd0: taken = a == b;
					3'd1: taken = a != b;
					3'd4: taken = $signed(a) < $signed(b);
					3'd5: taken = $signed(a) >= $signed(b);
					3'd6: taken = a < b;
					default: taken = a >= b;
				endcase
				if (taken) npc = fetch_pc + imm;
				inst = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11],
					rv_exec_pkg::OPC_BRANCH};
			end
			7: begin
				ctrl = 1'b1;
				res  = fetch_pc + 32'd4;
				if (rand_below(2) == 0) begin
					imm  = (rand_below(33) - 16) * 4;
					npc  = fetch_pc + imm;
					inst = {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_exec_pkg::OPC_JAL};
				end else begin
					// odd offsets check that bit 0 of the target is cleared
					imm  = rand_below(32) - 16;
					npc  = (a + imm) & ~32'd1;
					inst = {imm[11:0], rs1, 3'b000, rd, rv_exec_pkg::OPC_JALR};
				end
			end
			8, 9: begin
				// set up the base register for the memory access that follows
				rd           = 1 + rand_below(7);
				imm          = rand_below(rv_exec_pkg::DMEM_WORDS) * 4;
				res          = imm;
				inst         = {imm[11:0], 5'd0, 3'b000, rd, rv_exec_pkg::OPC_OPIMM};
				mem_pending  = 1'b1;
				mem_base_reg = rd;
			end
			default: begin
				mem_pending = 1'b0;
				is_load     = rand_below(2) == 0;
				if (is_load) begin
					case (rand_below(5))
						0: f3 = 3'd0;
						1: f3 = 3'd1;
						2: f3 = 3'd2;
						3: f3 = 3'd4;
						default: f3 = 3'd5;
					endcase
				end else begin
					f3 = rand_below(3);
				end
				size = 1 << f3[1:0];
				// mostly a small window so loads hit stored data
				if (rand_below(4) != 0) addr = rand_below(16) * 4;
				else addr = rand_below(rv_exec_pkg::DMEM_WORDS) * 4;
				addr = addr + (rand_below(4) & ~(size - 1));
				imm  = addr - a;
				if (is_load) begin
					for (i = 0; i < size; i++) res[8*i +: 8] = model_mem[addr + i];
					if (f3 == 3'd0) res = {{24{res[7]}}, res[7:0]};
					if (f3 == 3'd1) res = {{16{res[15]}}, res[15:0]};
					inst = {imm[11:0], rs1, f3, rd, rv_exec_pkg::OPC_LOAD};
				end else begin
					wen = 1'b0;
					for (i = 0; i < size; i++) model_mem[addr + i] = b[8*i +: 8];
					inst = {imm[11:5], rs2, rs1, f3, imm[4:0], rv_exec_pkg::OPC_STORE};
				end
			end
		endcase
		if (wen && rd != '0) model_regs[rd] = res;
		e.pc    = fetch_pc;
		e.npc   = npc;
		e.wen   = wen && rd != '0;
		e.waddr = rd;
		e.wdata = res;
		e.ctrl  = ctrl;
		exp_q.push_back(e);
		in_valid   <= 1'b1;
		in_pc      <= fetch_pc;
		in_inst    <= inst;
		presenting = 1'b1;
		cur_ctrl   = ctrl;
		generated++;
		if (!ctrl) fetch_pc = npc;
	endtask

	task automatic check_commit;
		commit_t e;

		assert (!(rf_wen && rf_waddr == '0)) else
			abort_run("register write to x0 was signalled");
		assert (!rf_wen || commit_valid) else
			abort_run("register write outside a commit cycle");
		if (commit_valid) begin
			assert (exp_q.size() > 0) else
				abort_run("commit seen with no instruction outstanding");
			e = exp_q.pop_front();
			check_word("commit_pc", e.pc, commit_pc);
			check_word("commit_next_pc", e.npc, commit_next_pc);
			check_word("rf_wen", {31'b0, e.wen}, {31'b0, rf_wen});
			if (e.wen) begin
				check_word("rf_waddr", {27'b0, e.waddr}, {27'b0, rf_waddr});
				check_word("rf_wdata", e.wdata, rf_wdata);
			end
			committed++;
			// fetch resumes at the resolved target
			if (e.ctrl) begin
				fetch_pc  = commit_next_pc;
				wait_ctrl = 1'b0;
			end
		end
	endtask

	task automatic fetch_step;
		if (presenting && in_ready) begin
			presenting = 1'b0;
			in_valid   <= 1'b0;
			if (cur_ctrl) wait_ctrl = 1'b1;
		end
		if (!presenting && !wait_ctrl && generated < N_INST) gen_next();
	endtask

	initial begin
		in_valid     <= 1'b0;
		in_pc        <= '0;
		in_inst      <= '0;
		fetch_pc     = 32'h0000_1000;
		presenting   = 1'b0;
		cur_ctrl     = 1'b0;
		wait_ctrl    = 1'b0;
		mem_pending  = 1'b0;
		mem_base_reg = '0;
		generated    = 0;
		committed    = 0;
		for (int i = 0; i < 32; i++) model_regs[i] = '0;
		for (int i = 0; i < 4*rv_exec_pkg::DMEM_WORDS; i++) model_mem[i] = '0;
		do @(posedge clk); while (rst);
		while (committed < N_INST) begin
			@(posedge clk);
			check_commit();
			fetch_step();
		end
		// no commit may follow the last instruction
		repeat (DRAIN_CYCLES) begin
			@(posedge clk);
			check_commit();
		end
		$display("** PASS **");
		$finish;
	end

	// watchdog
	initial begin
		repeat (N_INST * CYCLES_PER_INST + DRAIN_CYCLES) @(posedge clk);
		abort_run("timeout: not all instructions committed in time");
	end

endmodule

//--- verilog.f
rtl/rv_exec_pkg.sv
rtl/regfile.sv
rtl/idu.sv
rtl/alu.sv
rtl/exu.sv
rtl/dsram.sv
rtl/rv_backend_top.sv
testbench/tb_clock.sv
testbench/tb_rv_backend.sv

//--- Bender.yml
package:
  name: rv_backend

sources:
  - rtl/rv_exec_pkg.sv
  - rtl/regfile.sv
  - rtl/idu.sv
  - rtl/alu.sv
  - rtl/exu.sv
  - rtl/dsram.sv
  - rtl/rv_backend_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/tb_rv_backend.sv
